/* common/eflash_bus_pkg.sv */
package eflash_bus_pkg;

   // --------------------------------------------------
   // address map
   // --------------------------------------------------

   // word address is taken from byte address bits 17:2
   localparam int WORD_ADDR_LSB = 2;
   localparam int WORD_ADDR_MSB = 17;

   // word addresses below this are the main array
   localparam logic [15:0] INFO_BASE = 16'h8000;

   // control/status register, anything above is default region
   localparam logic [15:0] CTRL_REG_ADDR = 16'h8200;

   localparam logic [31:0] DEFAULT_RDATA = 32'h1234_5678;

   // --------------------------------------------------
   // channel types
   // --------------------------------------------------

   // id width carried by the bus structs
   localparam int BUS_ID_W = 4;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      SLVERR = 2'd2
   } resp_e;

   // shared by write address and read address channels
   typedef struct packed {
      logic [BUS_ID_W-1:0] id;
      logic [31:0]         addr;
   } addr_req_t;

   typedef struct packed {
      logic [BUS_ID_W-1:0] id;
      logic [31:0]         data;
   } rd_rsp_t;

endpackage

/* common/eflash_macro_pkg.sv */
package eflash_macro_pkg;

   // flash word address width
   localparam int FLASH_AW = 14;

   typedef enum logic [1:0] {
      OP_READ,
      OP_PROG,
      OP_PAGE_ERASE,
      OP_MACRO_ERASE
   } flash_op_e;

   // encoding is visible in the status word
   typedef enum logic [2:0] {
      ST_STANDBY     = 3'd0,
      ST_WRITE       = 3'd1,
      ST_READ        = 3'd2,
      ST_PAGE_ERASE  = 3'd3,
      ST_MACRO_ERASE = 3'd4
   } seq_state_e;

   typedef struct packed {
      flash_op_e           op;
      logic [FLASH_AW-1:0] addr;
      logic [31:0]         data;
      logic                info;
   } flash_cmd_t;

   // macro pin bundle
   typedef struct packed {
      logic [FLASH_AW-1:0] addr;
      logic [31:0]         din;
      logic                cs;
      logic                ae;
      logic                oe;
      logic                prog;
      logic                sera;
      logic                mase;
      logic                nvstr;
      logic                ifren;
      logic                resetb;
   } flash_pins_t;

endpackage

/* eflash_seq/eflash_seq.sv */
module eflash_seq
   import eflash_macro_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       i_cmd_start,
   input  flash_cmd_t i_cmd,
   input  logic       i_flash_tbit,
   output logic       o_idle,
   output seq_state_e o_state,
   output logic [2:0] o_phase,
   output logic       o_done,
   output logic       o_tbit_end
);

   seq_state_e state_q;
   seq_state_e state_d;
   logic [2:0] phase_q;
   logic       tbit_ff0;
   logic       tbit_ff1;
   logic       read_end;
   logic       nv_busy;

   // tbit comes from the macro, two flop synchronizer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tbit_ff0 <= 1'b0;
         tbit_ff1 <= 1'b0;
      end else begin
         tbit_ff0 <= i_flash_tbit;
         tbit_ff1 <= tbit_ff0;
      end
   end

   assign o_tbit_end = tbit_ff1 && !tbit_ff0;

   assign nv_busy  = (state_q != ST_STANDBY) && (state_q != ST_READ);
   // read data is ready on the second phase
   assign read_end = (state_q == ST_READ) && (phase_q == 3'd1);
   assign o_done   = read_end || (nv_busy && o_tbit_end);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_STANDBY: begin
            if (i_cmd_start) begin
               case (i_cmd.op)
                  OP_READ:        state_d = ST_READ;
                  OP_PROG:        state_d = ST_WRITE;
                  OP_PAGE_ERASE:  state_d = ST_PAGE_ERASE;
                  default:        state_d = ST_MACRO_ERASE;
               endcase
            end
         end
         ST_READ, ST_WRITE, ST_PAGE_ERASE, ST_MACRO_ERASE: begin
            if (o_done) begin
               state_d = ST_STANDBY;
            end
         end
         default: state_d = ST_STANDBY;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_STANDBY;
      end else begin
         state_q <= state_d;
      end
   end

   // cycles spent in the busy state, saturates at 7
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase_q <= 3'd0;
      end else if (o_done) begin
         phase_q <= 3'd0;
      end else if ((state_q != ST_STANDBY) && (phase_q != 3'd7)) begin
         phase_q <= phase_q + 3'd1;
      end
   end

   assign o_idle  = (state_q == ST_STANDBY);
   assign o_state = state_q;
   assign o_phase = phase_q;

endmodule

/* eflash_seq/eflash_pin_gen.sv */
module eflash_pin_gen
   import eflash_macro_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        i_cmd_start,
   input  flash_cmd_t  i_cmd,
   input  seq_state_e  i_state,
   input  logic [2:0]  i_phase,
   input  logic        i_tbit_end,
   output flash_pins_t o_pins
);

   logic                busy;
   logic                nv_busy;
   logic                rd_start;
   logic                nv_phase1;
   logic                addr_clr;
   logic [FLASH_AW-1:0] addr_q;
   logic                ifren_q;
   logic [31:0]         din_q;
   logic                ae_q;
   logic                oe_q;
   logic                prog_q;
   logic                sera_q;
   logic                mase_q;
   logic                nvstr_q;
   logic                resetb_pre;
   logic                resetb_q;

   assign busy      = (i_state != ST_STANDBY);
   // program and both erases share one pin sequence
   assign nv_busy   = busy && (i_state != ST_READ);
   assign rd_start  = i_cmd_start && (i_cmd.op == OP_READ);
   assign nv_phase1 = nv_busy && (i_phase == 3'd1);
   // address leaves the bus after the first phase
   assign addr_clr  = ((i_state == ST_READ) && (i_phase == 3'd0)) || nv_phase1;

   // --------------------------------------------------
   // address, info select and data in
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q  <= '0;
         ifren_q <= 1'b0;
      end else if (i_cmd_start) begin
         addr_q  <= i_cmd.addr;
         ifren_q <= i_cmd.info;
      end else if (addr_clr) begin
         addr_q  <= '0;
         ifren_q <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         din_q <= '1;
      end else if (i_cmd_start && (i_cmd.op == OP_PROG)) begin
         din_q <= i_cmd.data;
      end else if (nv_phase1) begin
         din_q <= '1;
      end
   end

   // --------------------------------------------------
   // strobes
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ae_q <= 1'b0;
         oe_q <= 1'b0;
      end else begin
         ae_q <= rd_start || (nv_busy && (i_phase == 3'd0));
         oe_q <= rd_start;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prog_q <= 1'b0;
         sera_q <= 1'b0;
         mase_q <= 1'b0;
      end else if (i_cmd_start) begin
         prog_q <= (i_cmd.op == OP_PROG);
         sera_q <= (i_cmd.op == OP_PAGE_ERASE);
         mase_q <= (i_cmd.op == OP_MACRO_ERASE);
      end else if (nv_phase1) begin
         prog_q <= 1'b0;
         sera_q <= 1'b0;
         mase_q <= 1'b0;
      end
   end

   // held until the macro drops tbit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         nvstr_q <= 1'b0;
      end else if (i_tbit_end) begin
         nvstr_q <= 1'b0;
      end else if (nv_phase1) begin
         nvstr_q <= 1'b1;
      end
   end

   // macro comes out of reset on the second clock
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resetb_pre <= 1'b0;
         resetb_q   <= 1'b0;
      end else begin
         resetb_pre <= 1'b1;
         resetb_q   <= resetb_pre;
      end
   end

   always_comb begin
      // read address goes out on the start cycle itself
      o_pins.addr   = rd_start ? i_cmd.addr : addr_q;
      o_pins.ifren  = rd_start ? i_cmd.info : ifren_q;
      o_pins.din    = din_q;
      o_pins.cs     = i_cmd_start || busy;
      o_pins.ae     = ae_q;
      o_pins.oe     = oe_q;
      o_pins.prog   = prog_q;
      o_pins.sera   = sera_q;
      o_pins.mase   = mase_q;
      o_pins.nvstr  = nvstr_q;
      o_pins.resetb = resetb_q;
   end

endmodule

/* hw/eflash_bus_slave.sv */
module eflash_bus_slave
   import eflash_bus_pkg::*, eflash_macro_pkg::*;
#(
   parameter int ID_W = BUS_ID_W
) (
   input  logic            clk,
   input  logic            rst_n,
   input  addr_req_t       i_aw,
   input  logic            i_aw_valid,
   output logic            o_aw_ready,
   input  logic [31:0]     i_w_data,
   input  logic            i_w_valid,
   output logic            o_w_ready,
   output logic [ID_W-1:0] o_b_id,
   output resp_e           o_b_resp,
   output logic            o_b_valid,
   input  logic            i_b_ready,
   input  addr_req_t       i_ar,
   input  logic            i_ar_valid,
   output logic            o_ar_ready,
   output rd_rsp_t         o_r,
   output resp_e           o_r_resp,
   output logic            o_r_valid,
   input  logic            i_r_ready,
   // sequencer side
   input  logic            i_idle,
   input  seq_state_e      i_state,
   input  logic            i_done,
   input  logic [31:0]     i_flash_dout,
   output logic            o_cmd_start,
   output flash_cmd_t      o_cmd
);

   typedef enum logic [1:0] {
      RG_ARRAY,
      RG_INFO,
      RG_CTRL,
      RG_DEFAULT
   } region_e;

   function automatic region_e classify(input logic [31:0] addr);
      logic [15:0] word;
      word = addr[WORD_ADDR_MSB:WORD_ADDR_LSB];
      if (word < INFO_BASE) begin
         return RG_ARRAY;
      end else if (word < CTRL_REG_ADDR) begin
         return RG_INFO;
      end else if (word == CTRL_REG_ADDR) begin
         return RG_CTRL;
      end
      return RG_DEFAULT;
   endfunction

   logic            aw_free;
   logic            w_free;
   logic            ar_free;
   logic [31:0]     aw_addr_q;
   logic [ID_W-1:0] b_id_q;
   logic [31:0]     wr_addr;
   region_e         wr_region;
   region_e         rd_region;
   logic            rd_to_flash;
   logic            wr_needs_seq;
   logic            aw_hs;
   logic            w_hs;
   logic            b_hs;
   logic            ar_hs;
   logic            r_hs;
   logic            rd_start;
   logic            prog_start;
   logic            erase_start;
   logic            ctrl_wr;
   logic            flash_rd_done;
   logic [7:0]      page_q;
   logic            macro_q;
   logic            erase_en_q;
   logic [31:0]     status_word;
   rd_rsp_t         r_q;

   // --------------------------------------------------
   // handshakes and region decode
   // --------------------------------------------------
   // W may arrive together with its AW
   assign wr_addr   = aw_free ? i_aw.addr : aw_addr_q;
   assign wr_region = classify(wr_addr);
   assign rd_region = classify(i_ar.addr);

   assign rd_to_flash  = (rd_region == RG_ARRAY) || (rd_region == RG_INFO);
   assign wr_needs_seq = (wr_region == RG_ARRAY) || (wr_region == RG_INFO)
                         || ((wr_region == RG_CTRL) && i_w_data[9]);

   assign o_aw_ready = aw_free;
   assign o_ar_ready = ar_free && (!rd_to_flash || i_idle);
   // reads win the sequencer when both arrive together
   assign o_w_ready  = w_free && (!aw_free || i_aw_valid)
                       && (!wr_needs_seq || (i_idle && !rd_start));

   assign aw_hs = i_aw_valid && o_aw_ready;
   assign w_hs  = i_w_valid && o_w_ready;
   assign b_hs  = o_b_valid && i_b_ready;
   assign ar_hs = i_ar_valid && o_ar_ready;
   assign r_hs  = o_r_valid && i_r_ready;

   assign rd_start      = ar_hs && rd_to_flash;
   assign ctrl_wr       = w_hs && (wr_region == RG_CTRL);
   assign prog_start    = w_hs && ((wr_region == RG_ARRAY) || (wr_region == RG_INFO));
   assign erase_start   = ctrl_wr && i_w_data[9];
   assign flash_rd_done = i_done && (i_state == ST_READ);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_free <= 1'b1;
         w_free  <= 1'b1;
      end else if (b_hs) begin
         aw_free <= 1'b1;
         w_free  <= 1'b1;
      end else begin
         if (aw_hs) begin
            aw_free <= 1'b0;
         end
         if (w_hs) begin
            w_free <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ar_free <= 1'b1;
      end else if (ar_hs) begin
         ar_free <= 1'b0;
      end else if (r_hs) begin
         ar_free <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         aw_addr_q <= i_aw.addr;
         b_id_q    <= i_aw.id[ID_W-1:0];
      end
   end

   // --------------------------------------------------
   // command to sequencer and pin generator
   // --------------------------------------------------
   assign o_cmd_start = rd_start || prog_start || erase_start;

   always_comb begin
      o_cmd.op   = OP_PROG;
      o_cmd.addr = wr_addr[WORD_ADDR_LSB +: FLASH_AW];
      o_cmd.data = i_w_data;
      o_cmd.info = (wr_region == RG_INFO);
      if (rd_start) begin
         o_cmd.op   = OP_READ;
         o_cmd.addr = i_ar.addr[WORD_ADDR_LSB +: FLASH_AW];
         o_cmd.data = '1;
         o_cmd.info = (rd_region == RG_INFO);
      end else if (erase_start) begin
         o_cmd.op   = i_w_data[8] ? OP_MACRO_ERASE : OP_PAGE_ERASE;
         // page base, 256 words per page
         o_cmd.addr = {i_w_data[5:0], 8'h00};
         o_cmd.data = '1;
         o_cmd.info = i_w_data[6];
      end
   end

   // control register, erase enable drops when the sequence ends
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         page_q     <= 8'h00;
         macro_q    <= 1'b0;
         erase_en_q <= 1'b0;
      end else if (ctrl_wr) begin
         page_q     <= i_w_data[7:0];
         macro_q    <= i_w_data[8];
         erase_en_q <= i_w_data[9];
      end else if (i_done) begin
         erase_en_q <= 1'b0;
      end
   end

   assign status_word = {i_state, 17'h0, i_idle, erase_en_q, macro_q, 1'b0, page_q};

   // --------------------------------------------------
   // responses
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         o_b_valid <= 1'b0;
         o_b_resp  <= OKAY;
      end else if (w_hs && (wr_region == RG_DEFAULT)) begin
         o_b_valid <= 1'b1;
         o_b_resp  <= SLVERR;
      end else if (ctrl_wr || (i_done && (i_state == ST_WRITE))) begin
         o_b_valid <= 1'b1;
         o_b_resp  <= OKAY;
      end else if (b_hs) begin
         o_b_valid <= 1'b0;
      end
   end

   assign o_b_id = b_id_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         o_r_valid <= 1'b0;
      end else if ((ar_hs && !rd_to_flash) || flash_rd_done) begin
         o_r_valid <= 1'b1;
      end else if (r_hs) begin
         o_r_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         r_q.id <= i_ar.id;
      end
      if (flash_rd_done) begin
         r_q.data <= i_flash_dout;
      end else if (ar_hs && (rd_region == RG_CTRL)) begin
         r_q.data <= status_word;
      end else if (ar_hs && (rd_region == RG_DEFAULT)) begin
         r_q.data <= DEFAULT_RDATA;
      end
   end

   assign o_r      = r_q;
   assign o_r_resp = OKAY;

endmodule

/* hw/eflash_ctrl_top.sv */
module eflash_ctrl_top
   import eflash_bus_pkg::*, eflash_macro_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   // write address
   input  addr_req_t           i_aw,
   input  logic                i_aw_valid,
   output logic                o_aw_ready,
   // write data
   input  logic [31:0]         i_w_data,
   input  logic                i_w_valid,
   output logic                o_w_ready,
   // write response
   output logic [BUS_ID_W-1:0] o_b_id,
   output resp_e               o_b_resp,
   output logic                o_b_valid,
   input  logic                i_b_ready,
   // read address
   input  addr_req_t           i_ar,
   input  logic                i_ar_valid,
   output logic                o_ar_ready,
   // read data
   output rd_rsp_t             o_r,
   output resp_e               o_r_resp,
   output logic                o_r_valid,
   input  logic                i_r_ready,
   // flash macro
   output flash_pins_t         o_pins,
   input  logic [31:0]         i_flash_dout,
   input  logic                i_flash_tbit
);

   localparam int ID_W = BUS_ID_W;

   logic       cmd_start;
   flash_cmd_t cmd;
   logic       seq_idle;
   seq_state_e seq_state;
   logic [2:0] seq_phase;
   logic       seq_done;
   logic       tbit_end;

   eflash_bus_slave #(
      .ID_W (ID_W)
   ) bus_slave_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_aw         (i_aw),
      .i_aw_valid   (i_aw_valid),
      .o_aw_ready   (o_aw_ready),
      .i_w_data     (i_w_data),
      .i_w_valid    (i_w_valid),
      .o_w_ready    (o_w_ready),
      .o_b_id       (o_b_id),
      .o_b_resp     (o_b_resp),
      .o_b_valid    (o_b_valid),
      .i_b_ready    (i_b_ready),
      .i_ar         (i_ar),
      .i_ar_valid   (i_ar_valid),
      .o_ar_ready   (o_ar_ready),
      .o_r          (o_r),
      .o_r_resp     (o_r_resp),
      .o_r_valid    (o_r_valid),
      .i_r_ready    (i_r_ready),
      .i_idle       (seq_idle),
      .i_state      (seq_state),
      .i_done       (seq_done),
      .i_flash_dout (i_flash_dout),
      .o_cmd_start  (cmd_start),
      .o_cmd        (cmd)
   );

   eflash_seq seq_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_cmd_start  (cmd_start),
      .i_cmd        (cmd),
      .i_flash_tbit (i_flash_tbit),
      .o_idle       (seq_idle),
      .o_state      (seq_state),
      .o_phase      (seq_phase),
      .o_done       (seq_done),
      .o_tbit_end   (tbit_end)
   );

   eflash_pin_gen pin_gen_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_cmd_start (cmd_start),
      .i_cmd       (cmd),
      .i_state     (seq_state),
      .i_phase     (seq_phase),
      .i_tbit_end  (tbit_end),
      .o_pins      (o_pins)
   );

endmodule

/* bench/eflash_macro_model.sv */
module eflash_macro_model
   import eflash_macro_pkg::*;
(
   input  logic        clk,
   input  flash_pins_t i_pins,
   output logic [31:0] o_dout,
   output logic        o_tbit
);

   timeunit 1ns;
   timeprecision 100ps;

   // sparse array keyed by {ifren, addr}, unwritten words read as erased
   logic [31:0]       mem [logic [FLASH_AW:0]];
   logic [31:0]       rng = 32'd24;
   logic [31:0]       dout_q = '1;
   logic              tbit_q = 1'b0;
   flash_op_e         op_q = OP_PROG;
   logic [FLASH_AW:0] key_q = '0;
   logic [31:0]       din_q = '1;
   int                busy_cnt = 0;
   logic              served = 1'b0;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] read_word(input logic [FLASH_AW:0] key);
      if (mem.exists(key)) begin
         return mem[key];
      end
      return '1;
   endfunction

   task automatic apply_op();
      int i;
      case (op_q)
         // programming only clears bits
         OP_PROG: mem[key_q] = read_word(key_q) & din_q;
         OP_PAGE_ERASE: begin
            for (i = 0; i < 256; i++) begin
               mem.delete({key_q[FLASH_AW:8], i[7:0]});
            end
         end
         OP_MACRO_ERASE: mem.delete();
         default: ;
      endcase
   endtask

   always @(posedge clk) begin
      if (i_pins.resetb && i_pins.cs && i_pins.oe) begin
         dout_q <= read_word({i_pins.ifren, i_pins.addr});
      end
      // operation is taken while ae is up, before nvstr
      if (i_pins.cs && i_pins.ae && (i_pins.prog || i_pins.sera || i_pins.mase)) begin
         key_q <= {i_pins.ifren, i_pins.addr};
         din_q <= i_pins.din;
         if (i_pins.prog) begin
            op_q <= OP_PROG;
         end else if (i_pins.sera) begin
            op_q <= OP_PAGE_ERASE;
         end else begin
            op_q <= OP_MACRO_ERASE;
         end
      end
      if (!i_pins.nvstr) begin
         served <= 1'b0;
      end
      if (busy_cnt > 0) begin
         busy_cnt <= busy_cnt - 1;
         if (busy_cnt == 1) begin
            tbit_q <= 1'b0;
            served <= 1'b1;
            apply_op();
         end
      end else if (i_pins.nvstr && !served) begin
         // busy time of 5 to 9 cycles
         rng = xorshift32(rng ^ din_q);
         busy_cnt <= 5 + int'(rng % 32'd5);
         tbit_q   <= 1'b1;
      end
   end

   assign o_dout = dout_q;
   assign o_tbit = tbit_q;

endmodule

/* bench/eflash_tb.sv */
module eflash_tb
   import eflash_bus_pkg::*, eflash_macro_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 200;
   localparam logic [31:0] CTRL_BYTE_ADDR = {14'h0, CTRL_REG_ADDR, 2'b00};

   logic                clk = 1'b0;
   logic                rst_n;
   addr_req_t           aw;
   logic                aw_valid;
   logic                aw_ready;
   logic [31:0]         w_data;
   logic                w_valid;
   logic                w_ready;
   logic [BUS_ID_W-1:0] b_id;
   resp_e               b_resp;
   logic                b_valid;
   logic                b_ready;
   addr_req_t           ar;
   logic                ar_valid;
   logic                ar_ready;
   rd_rsp_t             r;
   resp_e               r_resp;
   logic                r_valid;
   logic                r_ready;
   flash_pins_t         pins;
   logic [31:0]         flash_dout;
   logic                flash_tbit;

   int                  errors;
   int                  test_errs;
   bit                  timed_out;

   always #2 clk = ~clk;

   eflash_ctrl_top dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_aw         (aw),
      .i_aw_valid   (aw_valid),
      .o_aw_ready   (aw_ready),
      .i_w_data     (w_data),
      .i_w_valid    (w_valid),
      .o_w_ready    (w_ready),
      .o_b_id       (b_id),
      .o_b_resp     (b_resp),
      .o_b_valid    (b_valid),
      .i_b_ready    (b_ready),
      .i_ar         (ar),
      .i_ar_valid   (ar_valid),
      .o_ar_ready   (ar_ready),
      .o_r          (r),
      .o_r_resp     (r_resp),
      .o_r_valid    (r_valid),
      .i_r_ready    (r_ready),
      .o_pins       (pins),
      .i_flash_dout (flash_dout),
      .i_flash_tbit (flash_tbit)
   );

   eflash_macro_model macro_i (
      .clk    (clk),
      .i_pins (pins),
      .o_dout (flash_dout),
      .o_tbit (flash_tbit)
   );

   // main array and info region go through the sequencer
   function automatic bit in_flash(input logic [31:0] addr);
      return addr[WORD_ADDR_MSB:WORD_ADDR_LSB] < CTRL_REG_ADDR;
   endfunction

   task automatic report_test(input int num, input string what);
      $display("test %0d %s: %s", num, what, (test_errs == 0) ? "ok" : "FAIL");
      errors += test_errs;
      test_errs = 0;
   endtask

   // --------------------------------------------------
   // bus transactions
   // --------------------------------------------------
   // AW and W offered together, B sampled on a falling edge
   task automatic bus_write(input logic [BUS_ID_W-1:0] id, input logic [31:0] addr,
                            input logic [31:0] data, output resp_e resp,
                            output logic [BUS_ID_W-1:0] bid, output bit ok);
      int cnt;
      bit aw_done;
      bit w_done;
      aw_done  = 1'b0;
      w_done   = 1'b0;
      cnt      = 0;
      resp     = OKAY;
      bid      = '0;
      aw.id    = id;
      aw.addr  = addr;
      aw_valid = 1'b1;
      w_data   = data;
      w_valid  = 1'b1;
      while (!(aw_done && w_done) && cnt < TIMEOUT) begin
         @(negedge clk);
         aw_done = aw_done || aw_ready;
         w_done  = w_done || w_ready;
         @(posedge clk);
         #1;
         aw_valid = !aw_done;
         w_valid  = !w_done;
         cnt++;
      end
      ok = aw_done && w_done;
      if (!ok) begin
         aw_valid = 1'b0;
         w_valid  = 1'b0;
         $display("write to %h timed out waiting for the address and data handshake", addr);
         return;
      end
      cnt = 0;
      ok  = 1'b0;
      while (!ok && cnt < TIMEOUT) begin
         @(negedge clk);
         ok = b_valid;
         if (ok) begin
            resp = b_resp;
            bid  = b_id;
         end
         @(posedge clk);
         #1;
         cnt++;
      end
      if (!ok) begin
         $display("write to %h timed out waiting for the write response", addr);
      end
   endtask

   // lat counts cycles from the AR handshake cycle to the first valid cycle
   task automatic bus_read(input logic [BUS_ID_W-1:0] id, input logic [31:0] addr,
                           input int stall, output rd_rsp_t rsp, output resp_e resp,
                           output int lat, output bit ok);
      int cnt;
      int i;
      bit hs;
      hs       = 1'b0;
      cnt      = 0;
      lat      = 0;
      rsp      = '0;
      resp     = OKAY;
      ar.id    = id;
      ar.addr  = addr;
      ar_valid = 1'b1;
      r_ready  = (stall == 0);
      while (!hs && cnt < TIMEOUT) begin
         @(negedge clk);
         hs = ar_ready;
         @(posedge clk);
         #1;
         cnt++;
      end
      ar_valid = 1'b0;
      ok       = 1'b0;
      if (!hs) begin
         $display("read of %h timed out waiting for the address handshake", addr);
         return;
      end
      while (!ok && lat < TIMEOUT) begin
         @(negedge clk);
         lat++;
         ok = r_valid;
         if (!ok) begin
            @(posedge clk);
            #1;
         end
      end
      if (!ok) begin
         r_ready = 1'b1;
         $display("read of %h timed out waiting for read data", addr);
         return;
      end
      rsp  = r;
      resp = r_resp;
      // response must hold while the master stalls
      for (i = 0; i < stall; i++) begin
         @(posedge clk);
         #1;
         r_ready = (i == stall - 1);
         @(negedge clk);
         assert (r_valid && (r == rsp) && !ar_ready) else begin
            $display("MISMATCH at %0t: read response of %h not held in stall cycle %0d",
                     $time, addr, i + 1);
            test_errs++;
         end
      end
      @(posedge clk);
      #1;
      r_ready = 1'b1;
   endtask

   // poll status until the sequencer is back in standby with erase enable clear
   task automatic wait_erase_done(input logic [BUS_ID_W-1:0] id, output bit ok);
      rd_rsp_t rsp;
      resp_e   resp;
      int      lat;
      int      polls;
      bit      busy;
      busy  = 1'b1;
      polls = 0;
      ok    = 1'b1;
      while (ok && busy && polls < TIMEOUT) begin
         bus_read(id, CTRL_BYTE_ADDR, 0, rsp, resp, lat, ok);
         busy = (rsp.data[31:29] != 3'd0) || rsp.data[10];
         polls++;
      end
      if (ok && busy) begin
         ok = 1'b0;
         $display("erase timed out, status word still shows the sequencer busy");
      end
   endtask

   // --------------------------------------------------
   // reset and trace replay
   // --------------------------------------------------
   initial begin
      int                  fd;
      int                  n;
      int                  cnt;
      int                  tests;
      int                  lat;
      string               line;
      logic [15:0]         op;
      logic [31:0]         addr;
      logic [31:0]         data;
      logic [31:0]         exp;
      rd_rsp_t             rsp;
      resp_e               resp;
      logic [BUS_ID_W-1:0] bid;
      logic [BUS_ID_W-1:0] id;
      bit                  ok;

      errors    = 0;
      test_errs = 0;
      tests     = 0;
      timed_out = 1'b0;
      rst_n     = 1'b0;
      aw        = '0;
      aw_valid  = 1'b0;
      w_data    = '0;
      w_valid   = 1'b0;
      b_ready   = 1'b1;
      ar        = '0;
      ar_valid  = 1'b0;
      r_ready   = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      @(negedge clk);
      assert (!b_valid && !r_valid && aw_ready && ar_ready) else begin
         $display("MISMATCH at %0t: bus outputs not idle after reset", $time);
         test_errs++;
      end
      assert (!pins.cs && !pins.ae && !pins.oe && !pins.prog && !pins.sera && !pins.mase
              && !pins.nvstr && !pins.ifren && (pins.din == '1) && !pins.resetb) else begin
         $display("MISMATCH at %0t: flash pins not idle after reset", $time);
         test_errs++;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (pins.resetb) else begin
         $display("MISMATCH at %0t: flash resetb not released", $time);
         test_errs++;
      end
      @(posedge clk);
      #1;
      report_test(0, "reset");

      fd = $fopen("bench/eflash_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file bench/eflash_trace.txt");
         errors++;
      end else begin
         while (!timed_out && !$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#") begin
               n = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
               if (n == 4) begin
                  tests++;
                  id = tests[BUS_ID_W-1:0];
                  if (op == "WR") begin
                     bus_write(id, addr, data, resp, bid, ok);
                     if (ok) begin
                        assert (resp == resp_e'(exp[1:0])) else begin
                           $display("MISMATCH at %0t: write to %h got response %0d, expected %0d",
                                    $time, addr, resp, exp[1:0]);
                           test_errs++;
                        end
                        assert (bid == id) else begin
                           $display("MISMATCH at %0t: write to %h got id %h, expected %h",
                                    $time, addr, bid, id);
                           test_errs++;
                        end
                        // an erase start is followed by status polling
                        if (addr == CTRL_BYTE_ADDR && data[9]) begin
                           wait_erase_done(id, ok);
                        end
                     end
                  end else if (op == "RD") begin
                     bus_read(id, addr, int'(data), rsp, resp, lat, ok);
                     if (ok) begin
                        assert (rsp.data == exp) else begin
                           $display("MISMATCH at %0t: read of %h got %h, expected %h",
                                    $time, addr, rsp.data, exp);
                           test_errs++;
                        end
                        assert ((rsp.id == id) && (resp == OKAY)) else begin
                           $display("MISMATCH at %0t: read of %h got id %h resp %0d",
                                    $time, addr, rsp.id, resp);
                           test_errs++;
                        end
                        assert (lat == (in_flash(addr) ? 3 : 1)) else begin
                           $display("MISMATCH at %0t: read of %h took %0d cycles",
                                    $time, addr, lat);
                           test_errs++;
                        end
                     end
                  end else begin
                     $display("trace line %0d has an unknown operation", tests);
                     test_errs++;
                     ok = 1'b1;
                  end
                  if (!ok) begin
                     timed_out = 1'b1;
                     test_errs++;
                  end
                  report_test(tests, $sformatf("%s %h", op, addr));
               end
            end
         end
         $fclose(fd);
      end

      $display("%0d tests, %0d errors", tests + 1, errors);
      if (errors == 0 && !timed_out) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* bench/eflash_trace.txt */
# op addr data expect, all hex except op
# RD: data = cycles i_r_ready stays low after o_r_valid, expect = read data
# WR: data = write data, expect = write response (0 OKAY, 2 SLVERR)
WR 00000040 cafe0001 0
RD 00000040 0 cafe0001
WR 00000404 a5a50002 0
WR 00000800 00000003 0
RD 00000404 0 a5a50002
WR 00020800 00000201 0
RD 00000404 0 ffffffff
RD 00000800 0 00000003
WR 00020800 00000123 0
RD 00020800 0 00000a23
RD 00024000 0 12345678
WR 00024000 deadbeef 2
RD 00000040 4 cafe0001
WR 00020014 0badf00d 0
RD 00020014 0 0badf00d
RD 00000014 0 ffffffff
WR 00020800 00000300 0
RD 00020014 0 ffffffff
RD 00000040 0 ffffffff
RD 00000800 0 ffffffff
RD 00020800 0 00000a00

/* flist.f */
common/eflash_bus_pkg.sv
common/eflash_macro_pkg.sv
eflash_seq/eflash_seq.sv
eflash_seq/eflash_pin_gen.sv
hw/eflash_bus_slave.sv
hw/eflash_ctrl_top.sv
bench/eflash_macro_model.sv
bench/eflash_tb.sv

/* Makefile */
# Verilator simulation of the eflash controller

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the simulation with Verilator"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module eflash_tb -Mdir obj_dir -f flist.f
	@out="$$(./obj_dir/Veflash_tb)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
